// ==== filelist.f ====
+incdir+hdl
hdl/pix_pkg.sv
hdl/pix_stream_if.sv
hdl/frame_sync.sv
hdl/stream_ctrl.sv
hdl/test_pattern_gen.sv
hdl/frame_out.sv
hdl/stream_top.sv
verification/tb_stream_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the stream testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_stream_top

./obj_dir/Vtb_stream_top | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== verification/tb_stream_top.sv ====
`timescale 1ns/1ps

module tb_stream_top;
	import pix_pkg::*;

	// sum of the frames in tests 1 to 4
	localparam int NUM_FRAMES = 17;
	// idle cycles with fval low before each frame
	localparam int LEAD_GAP   = 16;
	// what happens at the start of row 1
	localparam int ACT_NONE     = 0;
	localparam int ACT_REGS     = 1;
	localparam int ACT_ACQ_DROP = 2;

	logic  clk_pix;
	logic  i_rst;
	logic  i_fval;
	logic  i_lval;
	pix_t  i_pix;
	logic  i_acquisition_start;
	logic  i_stream_enable;
	logic  i_license_ok;
	word_t i_pixel_format;
	logic  [2:0] i_test_image_sel;
	logic  o_req;
	word_t o_word;
	logic  o_sof;
	logic  i_ack;
	logic  o_enable;
	logic  o_full_frame_state;
	logic  o_overflow;

	integer seed = 32'h66c24531;
	int frame_w [NUM_FRAMES];
	int frame_h [NUM_FRAMES];
	int frame_idx = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	// predicted words carry sof in bit 32
	logic [32:0] model_q [$];
	logic [2:0]  lat_ti = 3'b000;
	logic        lat_single = 1'b0;
	pix_t        model_fcnt = '0;
	word_t       mid_fmt;
	logic [2:0]  mid_ti;

	string test_name = "reset";
	int test_num = 0;
	int cur_errs = 0;
	int cur_words = 0;
	int total_errs = 0;
	int hs_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;

	stream_top dut (
		.clk_pix             (clk_pix),
		.i_rst               (i_rst),
		.i_fval              (i_fval),
		.i_lval              (i_lval),
		.i_pix               (i_pix),
		.i_acquisition_start (i_acquisition_start),
		.i_stream_enable     (i_stream_enable),
		.i_license_ok        (i_license_ok),
		.i_pixel_format      (i_pixel_format),
		.i_test_image_sel    (i_test_image_sel),
		.o_req               (o_req),
		.o_word              (o_word),
		.o_sof               (o_sof),
		.i_ack               (i_ack),
		.o_enable            (o_enable),
		.o_full_frame_state  (o_full_frame_state),
		.o_overflow          (o_overflow)
	);

	// 100 ns pixel clock
	initial begin
		clk_pix = 1'b0;
		forever #50 clk_pix = ~clk_pix;
	end

	// ------------------------------
	// model helpers
	// ------------------------------

	// the four defined test image codes
	function automatic bit legal_code(input logic [2:0] code);
		case (code)
			TI_REAL, TI_GRAY_FRAME, TI_DIAG_STATIC, TI_DIAG_MOVING: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// pixel after the test image stage
	function automatic pix_t expected_pixel(input logic [2:0] ti, input pix_t px,
		input int col, input int row, input pix_t fcnt);
		pix_t diag;
		diag = pix_t'(col + row);
		case (ti)
			TI_GRAY_FRAME:  return fcnt;
			TI_DIAG_STATIC: return diag;
			TI_DIAG_MOVING: return diag + fcnt;
			default:        return px;
		endcase
	endfunction

	task automatic push_word(input logic sof, input word_t word);
		model_q.push_back({sof, word});
	endtask

	task automatic note_error();
		total_errs++;
		cur_errs++;
	endtask

	// handshake and reset failures count toward test 5
	task automatic count_handshake_error();
		total_errs++;
		hs_errs++;
	endtask

	task automatic next_cycle();
		@(posedge clk_pix);
		#1;
	endtask

	// ------------------------------
	// frame sizes and run limit
	// ------------------------------

	task automatic plan_frames();
		int total;
		total = 0;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			frame_w[i] = 4 * (1 + int'($unsigned($random(seed)) % 4));
			frame_h[i] = 2 + int'($unsigned($random(seed)) % 5);
			// lead gap plus two cycles to the first line and lines with 8x blanking
			total = total + LEAD_GAP + 3 + frame_h[i] * 9 * frame_w[i];
		end
		cycle_limit = total * 6 + 1000;
	endtask

	// ------------------------------
	// checks
	// ------------------------------

	task automatic check_word();
		logic [32:0] exp;
		cur_words++;
		assert (model_q.size() != 0) else begin
			$display("error test %s: expected no word, actual %h", test_name, o_word);
			note_error();
		end
		if (model_q.size() != 0) begin
			exp = model_q.pop_front();
			assert ({o_sof, o_word} == exp) else begin
				$display("error test %s: expected sof %b word %h, actual sof %b word %h",
					test_name, exp[32], exp[31:0], o_sof, o_word);
				note_error();
			end
		end
	endtask

	task automatic check_full_frame();
		assert (o_full_frame_state) else begin
			$display("error test %s: o_full_frame_state expected 1, actual 0", test_name);
			note_error();
		end
	endtask

	// req, enable, full frame, overflow
	task automatic check_reset_outputs();
		assert ({o_req, o_enable, o_full_frame_state, o_overflow} == 4'b0000) else begin
			$display("error test %s: control outputs expected 0000, actual %b", test_name,
				{o_req, o_enable, o_full_frame_state, o_overflow});
			count_handshake_error();
		end
	endtask

	// ------------------------------
	// sensor frame and model
	// ------------------------------

	task automatic send_frame(input int action);
		int w;
		int h;
		int pk_n;
		bit en;
		bit sof_pend;
		word_t pk;
		pix_t px;
		pix_t tp;
		w = frame_w[frame_idx];
		h = frame_h[frame_idx];
		frame_idx++;
		// settings the controller latches at this frame's rise
		en = i_stream_enable & i_acquisition_start & i_license_ok;
		if (legal_code(i_test_image_sel)) begin
			lat_ti = i_test_image_sel;
		end
		lat_single = i_pixel_format[0];
		sof_pend = 1'b1;
		pk_n = 0;
		pk = '0;
		repeat (LEAD_GAP) next_cycle();
		i_fval = 1'b1;
		repeat (2) next_cycle();
		for (int row = 0; row < h; row++) begin
			if (row == 1 && action == ACT_REGS) begin
				i_pixel_format = mid_fmt;
				i_test_image_sel = mid_ti;
			end
			if (row == 1 && action == ACT_ACQ_DROP) begin
				i_acquisition_start = 1'b0;
			end
			// flag should hold for the rest of the frame
			if (row >= 2 && action == ACT_ACQ_DROP) begin
				check_full_frame();
			end
			for (int col = 0; col < w; col++) begin
				px = pix_t'($random(seed));
				i_lval = 1'b1;
				i_pix = px;
				tp = expected_pixel(lat_ti, px, col, row, model_fcnt);
				if (en && lat_single) begin
					push_word(sof_pend, {24'h000000, tp});
					sof_pend = 1'b0;
				end else if (en) begin
					// first pixel goes in byte 0
					pk[pk_n*8 +: 8] = tp;
					pk_n++;
					if (pk_n == 4) begin
						push_word(sof_pend, pk);
						sof_pend = 1'b0;
						pk_n = 0;
						pk = '0;
					end
				end
				next_cycle();
			end
			i_lval = 1'b0;
			i_pix = '0;
			repeat (8 * w) next_cycle();
		end
		if (action == ACT_ACQ_DROP) begin
			check_full_frame();
		end
		// partial word keeps its upper bytes zero
		if (pk_n != 0) begin
			push_word(sof_pend, pk);
		end
		i_fval = 1'b0;
		next_cycle();
		// gray level and moving diagonal step per passed frame
		if (en) begin
			model_fcnt++;
		end
	endtask

	task automatic start_test(input int num, input string name);
		test_num = num;
		test_name = name;
		cur_errs = 0;
		cur_words = 0;
	endtask

	task automatic finish_test();
		while (model_q.size() != 0) begin
			@(posedge clk_pix);
		end
		// room for stray words
		repeat (60) next_cycle();
		tests_run++;
		if (cur_errs == 0) begin
			$display("test %0d %s: ok, %0d words", test_num, test_name, cur_words);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors, %0d words", test_num, test_name,
				cur_errs, cur_words);
		end
	endtask

	// ------------------------------
	// receiver with a random ack delay
	// ------------------------------

	initial begin : receiver
		int dly;
		i_ack = 1'b0;
		forever begin
			@(negedge clk_pix);
			if (o_req && !i_ack) begin
				dly = int'($unsigned($random(seed)) % 4);
				repeat (dly) @(negedge clk_pix);
				check_word();
				@(posedge clk_pix);
				#1 i_ack = 1'b1;
				do @(negedge clk_pix); while (o_req);
				@(posedge clk_pix);
				#1 i_ack = 1'b0;
			end
		end
	end

	// four-phase rules sampled mid-cycle
	initial begin : monitor
		logic req_prev;
		logic ack_prev;
		logic [32:0] held;
		bit ovf_seen;
		req_prev = 1'b0;
		ack_prev = 1'b0;
		held = '0;
		ovf_seen = 1'b0;
		forever begin
			@(negedge clk_pix);
			if (!i_rst) begin
				// ack as the DUT saw it at the edge that raised o_req
				if (o_req && !req_prev) begin
					assert (!ack_prev) else begin
						$display("o_req rose while i_ack was still high");
						count_handshake_error();
					end
				end
				if (o_req && req_prev) begin
					assert ({o_sof, o_word} == held) else begin
						$display("error test %s: held word expected %h, actual %h", test_name,
							held, {o_sof, o_word});
						count_handshake_error();
					end
				end
				if (!ovf_seen) begin
					assert (!o_overflow) else begin
						ovf_seen = 1'b1;
						$display("o_overflow was set, output words were lost");
						count_handshake_error();
					end
				end
			end
			req_prev = o_req;
			ack_prev = i_ack;
			held = {o_sof, o_word};
		end
	end

	// limit set at time zero by the main process
	initial begin : watchdog
		@(posedge clk_pix);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_pix);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", cycle_limit);
		$display("TEST FAIL");
		$finish;
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin : main
		i_rst = 1'b1;
		i_fval = 1'b0;
		i_lval = 1'b0;
		i_pix = '0;
		i_acquisition_start = 1'b0;
		i_stream_enable = 1'b0;
		i_license_ok = 1'b0;
		i_pixel_format = '0;
		i_test_image_sel = TI_REAL;
		mid_fmt = '0;
		mid_ti = TI_REAL;
		plan_frames();
		repeat (4) @(posedge clk_pix);
		#1 i_rst = 1'b0;
		check_reset_outputs();

		start_test(1, "packed real image");
		i_stream_enable = 1'b1;
		i_acquisition_start = 1'b1;
		i_license_ok = 1'b1;
		repeat (3) send_frame(ACT_NONE);
		finish_test();

		start_test(2, "single mode and test images");
		i_pixel_format = 32'h1;
		send_frame(ACT_NONE);
		i_test_image_sel = TI_GRAY_FRAME;
		send_frame(ACT_NONE);
		i_test_image_sel = TI_DIAG_STATIC;
		send_frame(ACT_NONE);
		i_test_image_sel = TI_DIAG_MOVING;
		send_frame(ACT_NONE);
		// moving diagonal again in packed mode
		i_pixel_format = 32'h0;
		send_frame(ACT_NONE);
		finish_test();

		start_test(3, "mid-frame register change");
		i_test_image_sel = TI_DIAG_STATIC;
		mid_fmt = 32'h1;
		mid_ti = TI_DIAG_MOVING;
		send_frame(ACT_REGS);
		send_frame(ACT_NONE);
		// illegal code keeps the moving diagonal
		i_pixel_format = 32'h0;
		i_test_image_sel = 3'b111;
		send_frame(ACT_NONE);
		i_test_image_sel = TI_REAL;
		finish_test();

		start_test(4, "enable gating");
		i_stream_enable = 1'b0;
		send_frame(ACT_NONE);
		i_stream_enable = 1'b1;
		i_acquisition_start = 1'b0;
		send_frame(ACT_NONE);
		i_acquisition_start = 1'b1;
		i_license_ok = 1'b0;
		send_frame(ACT_NONE);
		i_license_ok = 1'b1;
		send_frame(ACT_ACQ_DROP);
		// acquisition still stopped so this frame is dropped
		send_frame(ACT_NONE);
		i_acquisition_start = 1'b1;
		send_frame(ACT_NONE);
		finish_test();

		start_test(5, "handshake and reset");
		assert (!o_overflow) else begin
			$display("o_overflow was set by the end of the traffic");
			count_handshake_error();
		end
		i_rst = 1'b1;
		repeat (4) next_cycle();
		i_rst = 1'b0;
		check_reset_outputs();
		cur_errs = cur_errs + hs_errs;
		finish_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errs);
		if (total_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/stream_top.sv ====
`timescale 1ns/1ps

module stream_top (
	input  logic           clk_pix,
	input  logic           i_rst,
	input  logic           i_fval,
	input  logic           i_lval,
	input  pix_pkg::pix_t  i_pix,
	input  logic           i_acquisition_start,
	input  logic           i_stream_enable,
	input  logic           i_license_ok,
	input  pix_pkg::word_t i_pixel_format,
	input  logic [2:0]     i_test_image_sel,
	output logic           o_req,
	output pix_pkg::word_t o_word,
	output logic           o_sof,
	input  logic           i_ack,
	output logic           o_enable,
	output logic           o_full_frame_state,
	output logic           o_overflow
);
	import pix_pkg::*;

	// settings latched at frame start
	word_t       pixel_format;
	test_image_t test_image_sel;

	// ------------------------------
	// internal streams
	// ------------------------------

	// after the sync buffer
	pix_stream_if s_sync ();
	// after the test image stage
	pix_stream_if s_gen ();

	frame_sync u_frame_sync (
		.clk_pix  (clk_pix),
		.i_rst    (i_rst),
		.i_fval   (i_fval),
		.i_lval   (i_lval),
		.i_pix    (i_pix),
		.o_stream (s_sync.src)
	);

	// the synced frame valid goes to the controller as a plain wire
	stream_ctrl u_stream_ctrl (
		.clk_pix             (clk_pix),
		.i_rst               (i_rst),
		.i_fval              (i_fval),
		.i_fval_sync         (s_sync.fval),
		.i_acquisition_start (i_acquisition_start),
		.i_stream_enable     (i_stream_enable),
		.i_license_ok        (i_license_ok),
		.i_pixel_format      (i_pixel_format),
		.i_test_image_sel    (i_test_image_sel),
		.o_enable            (o_enable),
		.o_full_frame_state  (o_full_frame_state),
		.o_pixel_format      (pixel_format),
		.o_test_image_sel    (test_image_sel)
	);

	test_pattern_gen u_test_pattern_gen (
		.clk_pix          (clk_pix),
		.i_rst            (i_rst),
		.i_enable         (o_enable),
		.i_test_image_sel (test_image_sel),
		.i_stream         (s_sync.snk),
		.o_stream         (s_gen.src)
	);

	frame_out u_frame_out (
		.clk_pix        (clk_pix),
		.i_rst          (i_rst),
		.i_pixel_format (pixel_format),
		.i_stream       (s_gen.snk),
		.o_req          (o_req),
		.o_word         (o_word),
		.o_sof          (o_sof),
		.i_ack          (i_ack),
		.o_overflow     (o_overflow)
	);

endmodule

// ==== hdl/frame_out.sv ====
`timescale 1ns/1ps
`include "pix_settings.svh"

module frame_out (
	input  logic           clk_pix,
	input  logic           i_rst,
	input  pix_pkg::word_t i_pixel_format,
	pix_stream_if.snk      i_stream,
	output logic           o_req,
	output pix_pkg::word_t o_word,
	output logic           o_sof,
	input  logic           i_ack,
	output logic           o_overflow
);
	import pix_pkg::*;

	localparam int AW = $clog2(`OUT_FIFO_DEPTH);

	// release waits for ack low before the next request
	typedef enum logic [1:0] {S_IDLE, S_REQ, S_REL} send_state_t;

	pix_fmt_t        fmt;
	logic            fval_d;
	logic [1:0]      pk_idx;
	word_t           pk_word;
	word_t           pk_next;
	logic            pk_sof;
	logic            cur_sof;
	logic            flush;
	logic            push_go;
	logic            push_vld;
	word_t           push_word;
	logic            push_sof;
	logic [`REG_WD:0] fifo_mem [0:`OUT_FIFO_DEPTH-1];
	logic [AW:0]     wr_ptr;
	logic [AW:0]     rd_ptr;
	logic            full;
	logic            empty;
	logic            pop;
	send_state_t     state;

	// ------------------------------
	// word packer
	// ------------------------------

	always_comb begin
		fmt = pix_fmt_t'(i_pixel_format[0]);
		// byte 0 starts a clean word, upper bytes stay zero
		pk_next = (pk_idx == 2'd0) ? '0 : pk_word;
		pk_next[pk_idx*`PIX_WD +: `PIX_WD] = i_stream.pix;
		cur_sof = (pk_idx == 2'd0) ? i_stream.sof : pk_sof;
		// partial word left at frame end
		flush   = fval_d & ~i_stream.fval & (pk_idx != 2'd0);
		push_go = (i_stream.lval & ((fmt == FMT_SINGLE) | (pk_idx == 2'd3))) | flush;
	end

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			fval_d   <= 1'b0;
			pk_idx   <= '0;
			pk_sof   <= 1'b0;
			push_vld <= 1'b0;
		end else begin
			fval_d   <= i_stream.fval;
			push_vld <= push_go;
			if (i_stream.lval) begin
				pk_idx <= (fmt == FMT_SINGLE) ? 2'd0 : pk_idx + 1'b1;
				if (pk_idx == 2'd0) begin
					pk_sof <= i_stream.sof;
				end
			end else if (flush) begin
				pk_idx <= '0;
			end
		end
	end

	always_ff @(posedge clk_pix) begin
		if (i_stream.lval) begin
			pk_word <= pk_next;
		end
		if (push_go) begin
			push_word <= i_stream.lval ? pk_next : pk_word;
			push_sof  <= i_stream.lval ? cur_sof : pk_sof;
		end
	end

	// ------------------------------
	// word fifo, sof kept in msb
	// ------------------------------

	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign pop   = (state == S_IDLE) && !empty && !i_ack;

	always_ff @(posedge clk_pix) begin
		if (push_vld && !full) begin
			fifo_mem[wr_ptr[AW-1:0]] <= {push_sof, push_word};
		end
	end

	// overflow is sticky until reset
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (push_vld && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end else if (push_vld) begin
				o_overflow <= 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ------------------------------
	// four-phase sender
	// ------------------------------

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			state <= S_IDLE;
			o_req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (pop) begin
					o_req <= 1'b1;
					state <= S_REQ;
				end
				S_REQ: if (i_ack) begin
					o_req <= 1'b0;
					state <= S_REL;
				end
				S_REL: if (!i_ack) begin
					state <= S_IDLE;
				end
				default: begin
					o_req <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// word and sof held for the whole request
	always_ff @(posedge clk_pix) begin
		if (pop) begin
			{o_sof, o_word} <= fifo_mem[rd_ptr[AW-1:0]];
		end
	end

endmodule

// ==== hdl/test_pattern_gen.sv ====
`timescale 1ns/1ps

module test_pattern_gen (
	input  logic                 clk_pix,
	input  logic                 i_rst,
	input  logic                 i_enable,
	input  pix_pkg::test_image_t i_test_image_sel,
	pix_stream_if.snk            i_stream,
	pix_stream_if.src            o_stream
);
	import pix_pkg::*;

	logic fval_d;
	logic lval_d;
	// enable captured at this frame's sof
	logic frame_en;
	logic frame_en_cur;
	logic pix_vld;
	// position of the incoming pixel, low 8 bits suffice
	pix_t col_cnt;
	pix_t row_cnt;
	pix_t frame_cnt;
	pix_t diag;
	pix_t test_pix;

	// ------------------------------
	// frame gate and pixel select
	// ------------------------------

	always_comb begin
		frame_en_cur = i_stream.sof ? i_enable : frame_en;
		pix_vld      = i_stream.lval & frame_en_cur;
		diag         = col_cnt + row_cnt;
		case (i_test_image_sel)
			// one gray level per frame
			TI_GRAY_FRAME:  test_pix = frame_cnt;
			TI_DIAG_STATIC: test_pix = diag;
			// diagonal shifts by one each frame
			TI_DIAG_MOVING: test_pix = diag + frame_cnt;
			default:        test_pix = i_stream.pix;
		endcase
	end

	// ------------------------------
	// position and frame counters
	// ------------------------------

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			fval_d    <= 1'b0;
			lval_d    <= 1'b0;
			frame_en  <= 1'b0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			frame_cnt <= '0;
		end else begin
			fval_d <= i_stream.fval;
			lval_d <= i_stream.lval;
			if (i_stream.sof) begin
				frame_en <= i_enable;
			end
			// column restarts in line blanking
			if (i_stream.lval) begin
				col_cnt <= col_cnt + 1'b1;
			end else begin
				col_cnt <= '0;
			end
			// row steps at each line end
			if (!i_stream.fval) begin
				row_cnt <= '0;
			end else if (lval_d && !i_stream.lval) begin
				row_cnt <= row_cnt + 1'b1;
			end
			// passed frames only
			if (fval_d && !i_stream.fval && frame_en) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// output register, 1 clock
	// ------------------------------

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_stream.fval <= 1'b0;
			o_stream.lval <= 1'b0;
			o_stream.sof  <= 1'b0;
		end else begin
			o_stream.fval <= i_stream.fval;
			o_stream.lval <= pix_vld;
			o_stream.sof  <= i_stream.sof & i_enable;
		end
	end

	always_ff @(posedge clk_pix) begin
		o_stream.pix <= test_pix;
	end

endmodule

// ==== hdl/stream_ctrl.sv ====
`timescale 1ns/1ps

module stream_ctrl (
	input  logic                 clk_pix,
	input  logic                 i_rst,
	input  logic                 i_fval,
	input  logic                 i_fval_sync,
	input  logic                 i_acquisition_start,
	input  logic                 i_stream_enable,
	input  logic                 i_license_ok,
	input  pix_pkg::word_t       i_pixel_format,
	input  logic [2:0]           i_test_image_sel,
	output logic                 o_enable,
	output logic                 o_full_frame_state,
	output pix_pkg::word_t       o_pixel_format,
	output pix_pkg::test_image_t o_test_image_sel
);
	import pix_pkg::*;

	logic [2:0] fval_shift;
	logic       fval_rise;
	logic [1:0] license_sync;
	logic       ti_legal;

	// ------------------------------
	// frame valid sampling
	// ------------------------------

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			fval_shift <= '0;
		end else begin
			fval_shift <= {fval_shift[1:0], i_fval};
		end
	end

	// rise seen between stages 1 and 2
	assign fval_rise = fval_shift[1] & ~fval_shift[2];

	// license state lives in another clock, two flops
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			license_sync <= '0;
		end else begin
			license_sync <= {license_sync[0], i_license_ok};
		end
	end

	// ------------------------------
	// frame-safe enable
	// ------------------------------

	// only while neither raw nor synced frame is open
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_enable <= 1'b0;
		end else if (!fval_shift[1] && !i_fval_sync) begin
			o_enable <= i_stream_enable & i_acquisition_start & license_sync[1];
		end
	end

	// stop during an open frame, that frame still completes
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_full_frame_state <= 1'b0;
		end else if (!i_stream_enable || !i_fval_sync) begin
			o_full_frame_state <= 1'b0;
		end else if (!i_acquisition_start) begin
			o_full_frame_state <= 1'b1;
		end
	end

	// ------------------------------
	// frame-start register latch
	// ------------------------------

	// the four defined test image codes
	always_comb begin
		case (i_test_image_sel)
			TI_REAL, TI_GRAY_FRAME, TI_DIAG_STATIC, TI_DIAG_MOVING: ti_legal = 1'b1;
			default: ti_legal = 1'b0;
		endcase
	end

	// illegal code keeps the previous image
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			o_pixel_format   <= '0;
			o_test_image_sel <= TI_REAL;
		end else if (fval_rise) begin
			o_pixel_format <= i_pixel_format;
			if (ti_legal) begin
				o_test_image_sel <= test_image_t'(i_test_image_sel);
			end
		end
	end

endmodule

// ==== hdl/frame_sync.sv ====
`timescale 1ns/1ps

module frame_sync (
	input  logic         clk_pix,
	input  logic         i_rst,
	input  logic         i_fval,
	input  logic         i_lval,
	input  pix_pkg::pix_t i_pix,
	pix_stream_if.src    o_stream
);
	import pix_pkg::*;

	// armed between frames, cleared by the first line
	logic       sof_armed;
	logic       sof_in;
	logic [3:0] fval_dly;
	logic [3:0] lval_dly;
	logic [3:0] sof_dly;
	pix_t       pix_dly [4];

	// ------------------------------
	// start of frame detect
	// ------------------------------

	// first lval-high cycle inside a frame
	assign sof_in = i_fval & i_lval & sof_armed;

	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			sof_armed <= 1'b0;
		end else if (!i_fval) begin
			sof_armed <= 1'b1;
		end else if (i_lval) begin
			sof_armed <= 1'b0;
		end
	end

	// ------------------------------
	// 4-deep sync buffer
	// ------------------------------

	// framing bits
	always_ff @(posedge clk_pix) begin
		if (i_rst) begin
			fval_dly <= '0;
			lval_dly <= '0;
			sof_dly  <= '0;
		end else begin
			fval_dly <= {fval_dly[2:0], i_fval};
			lval_dly <= {lval_dly[2:0], i_lval};
			sof_dly  <= {sof_dly[2:0], sof_in};
		end
	end

	// pixel data, same depth
	always_ff @(posedge clk_pix) begin
		pix_dly[0] <= i_pix;
		for (int i = 1; i < 4; i++) begin
			pix_dly[i] <= pix_dly[i-1];
		end
	end

	assign o_stream.fval = fval_dly[3];
	assign o_stream.lval = lval_dly[3];
	assign o_stream.sof  = sof_dly[3];
	assign o_stream.pix  = pix_dly[3];

endmodule

// ==== hdl/pix_stream_if.sv ====
`timescale 1ns/1ps

interface pix_stream_if;
	import pix_pkg::*;

	// frame valid, high for the whole frame
	logic fval;
	// line valid, pixel is valid while high
	logic lval;
	// first valid pixel of the frame
	logic sof;
	// mono pixel
	pix_t pix;

	// driving side
	modport src (
		output fval,
		output lval,
		output sof,
		output pix
	);

	// receiving side
	modport snk (
		input fval,
		input lval,
		input sof,
		input pix
	);
endinterface

// ==== hdl/pix_pkg.sv ====
`include "pix_settings.svh"

package pix_pkg;

	// ------------------------------
	// payload types
	// ------------------------------

	// one sensor pixel
	typedef logic [`PIX_WD-1:0] pix_t;

	// one packed output word
	typedef logic [`REG_WD-1:0] word_t;

	// ------------------------------
	// register encodings
	// ------------------------------

	// test image select, the other four codes are illegal
	typedef enum logic [2:0] {
		TI_REAL        = 3'b000,
		TI_GRAY_FRAME  = 3'b001,
		TI_DIAG_STATIC = 3'b110,
		TI_DIAG_MOVING = 3'b010
	} test_image_t;

	// bit 0 of the pixel format register
	typedef enum logic {
		FMT_PACKED4 = 1'b0,
		FMT_SINGLE  = 1'b1
	} pix_fmt_t;

endpackage

// ==== hdl/pix_settings.svh ====
`ifndef PIX_SETTINGS_SVH
`define PIX_SETTINGS_SVH

// ------------------------------
// video path widths
// ------------------------------

// mono pixel, one byte
`define PIX_WD 8

// register word, also the output word
`define REG_WD 32

// ------------------------------
// output buffering
// ------------------------------

// word entries in the output fifo
`define OUT_FIFO_DEPTH 64

`endif
